// ==== dg_top.f ====
+incdir+.
dg_pkg.sv
host_bus_if.sv
pulse_timing_if.sv
protocol_sequencer.sv
delay_channel.sv
output_stage.sv
dg_top.sv
tb_dg_checker.sv
tb_dg_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dg_top
FILELIST = dg_top.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) dg_defs.svh $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJDIR)

// ==== tb_dg_top.sv ====
// delay generator testbench
// applies a table of bus operations and expected values to the DUT
// while the checker module compares the responses
`timescale 1ns/1ns
`include "dg_defs.svh"

module tb_dg_top;
   import dg_pkg::*;

   localparam logic [3:0] OP_WR   = 4'd0;
   localparam logic [3:0] OP_RD   = 4'd1;   // data holds the read kind
   localparam logic [3:0] OP_SYNC = 4'd2;   // data holds the dg_t0 count
   localparam logic [3:0] OP_EXP  = 4'd3;   // page and polarity in data
   localparam logic [3:0] OP_HOLD = 4'd4;
   localparam dg_word_t   ALL     = '1;

   typedef struct packed {
      logic [3:0] op;
      dg_addr_t   addr;
      dg_word_t   data;
      dg_word_t   exp;
      dg_word_t   mask;
   } entry_t;

   logic clk100 = 1'b0;
   logic hps_fpga_reset_n;
   logic bus_write;
   logic bus_read;
   dg_addr_t bus_addr;
   dg_word_t bus_wdata;
   dg_word_t bus_rdata;
   logic bus_rvalid;
   dg_pins_t dg_pins;
   logic dg_t0;

   logic       chk_en;
   dg_time_t   exp_interval;
   dg_word_t   exp_pairs [`DG_NCHANNELS];
   dg_pins_t   exp_polarity;
   logic [1:0] rd_kind;
   dg_word_t   rd_exp;
   dg_word_t   rd_mask;
   int         chk_errors;

   entry_t   steps[$];
   dg_word_t page_vals [`DG_NPAGES][`DG_NCHANNELS];
   integer   seed = 32'hdafe7c1b;
   int       tb_errors = 0;
   int       total_periods = 0;
   logic     built = 1'b0;

   always #5 clk100 = ~clk100;

   dg_top dut (.*);

   tb_dg_checker chk (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .dg_t0            (dg_t0),
      .dg_pins          (dg_pins),
      .bus_read         (bus_read),
      .bus_rvalid       (bus_rvalid),
      .bus_rdata        (bus_rdata),
      .chk_en           (chk_en),
      .exp_interval     (exp_interval),
      .exp_pairs        (exp_pairs),
      .exp_polarity     (exp_polarity),
      .rd_kind          (rd_kind),
      .rd_exp           (rd_exp),
      .rd_mask          (rd_mask),
      .errors           (chk_errors)
   );

   task automatic add(input logic [3:0] op, input int addr, input dg_word_t data,
                      input dg_word_t exp, input dg_word_t mask);
      steps.push_back({op, dg_addr_t'(addr), data, exp, mask});
      if (op == OP_SYNC) total_periods += int'(data);
   endtask

   task automatic wait_t0();
      int n;
      n = 0;
      @(negedge clk100);
      while (!dg_t0 && n < 3 * `DG_RESET_INTERVAL) begin
         @(negedge clk100);
         n++;
      end
      if (!dg_t0) begin
         tb_errors++;
         $display("no dg_t0 pulse seen within %0d cycles", 3 * `DG_RESET_INTERVAL);
      end
   endtask

   task automatic wait_rvalid();
      int n;
      n = 0;
      while (!bus_rvalid && n < 4) begin
         @(negedge clk100);
         n++;
      end
      if (!bus_rvalid) begin
         tb_errors++;
         $display("read at address %0d got no rvalid", bus_addr);
      end
      @(negedge clk100);   // checker samples rvalid on this edge
   endtask

   // ====================
   // stimulus table
   // ====================
   task automatic build_table();
      logic [31:0] d;
      logic [31:0] w;
      for (int p = 0; p < `DG_NPAGES; p++) begin
         for (int c = 0; c < `DG_NCHANNELS; c++) begin
            d = $random(seed);
            w = $random(seed);
            page_vals[p][c] = {d % 400, 32'd1 + w % 399};   // sum stays below 1000
         end
      end
      add(OP_EXP, 0, 64'h4, `DG_RESET_INTERVAL, 0);        // zero pairs with mask cleared
      add(OP_SYNC, 0, 3, 0, 0);
      add(OP_WR, `DG_REG_FLAGS, 1, 0, 0);                  // page 1
      for (int c = 0; c < `DG_NCHANNELS; c++)
         add(OP_WR, `DG_REG_PAIR0 + c, page_vals[1][c], 0, 0);
      add(OP_RD, `DG_REG_PAIR0 + 3, 0, page_vals[1][3], ALL);
      add(OP_WR, `DG_REG_INTERVAL, 500, 0, 0);             // below the minimum
      add(OP_RD, `DG_REG_INTERVAL, 0, 500, ALL);
      add(OP_WR, `DG_REG_FLAGS, 2, 0, 0);                  // page 2 stays uncommitted
      for (int c = 0; c < `DG_NCHANNELS; c++)
         add(OP_WR, `DG_REG_PAIR0 + c, page_vals[2][c], 0, 0);
      add(OP_RD, `DG_REG_PAIR0 + 5, 0, page_vals[2][5], ALL);
      add(OP_HOLD, 0, 0, 0, 0);
      add(OP_WR, `DG_REG_COMMIT, 3, 0, 0);                 // commit page 1
      add(OP_SYNC, 0, 2, 0, 0);
      add(OP_EXP, 0, 64'h1, `DG_MIN_INTERVAL, 0);
      add(OP_SYNC, 0, 3, 0, 0);
      add(OP_WR, `DG_REG_FLAGS, 4, 0, 0);                  // view active values
      add(OP_RD, `DG_REG_INTERVAL, 0, `DG_MIN_INTERVAL, ALL);
      add(OP_RD, `DG_REG_PAIR0, 0, page_vals[1][0], ALL);
      add(OP_RD, `DG_REG_PAIR0 + 6, 0, page_vals[1][6], ALL);
      add(OP_RD, `DG_REG_STATUS, 0, 1, 64'hffffffff);      // active page
      add(OP_WR, `DG_REG_FLAGS, 2, 0, 0);
      add(OP_RD, `DG_REG_PAIR0 + 2, 0, page_vals[2][2], ALL);
      add(OP_HOLD, 0, 0, 0, 0);
      add(OP_WR, `DG_REG_POLARITY, 'b00101, 0, 0);         // push and eject high
      add(OP_SYNC, 0, 1, 0, 0);
      add(OP_EXP, 0, 64'h501, `DG_MIN_INTERVAL, 0);
      add(OP_SYNC, 0, 3, 0, 0);
      for (int k = 0; k < 2; k++) begin
         add(OP_SYNC, 0, 1, 0, 0);
         add(OP_RD, `DG_REG_TIMESTAMP, 1, 0, 0);
      end
      for (int k = 0; k < 2; k++) begin
         add(OP_SYNC, 0, 1, 0, 0);
         add(OP_RD, `DG_REG_STATUS, 2, 0, 0);
      end
      add(OP_RD, `DG_REG_COMMIT, 0, {32'(`DG_MODEL_NUMBER), 32'h0}, 64'hffffffff_00000000);
   endtask

   // watchdog from the programmed periods
   initial begin : watchdog
      time limit;
      wait (built);
      limit = time'(total_periods) * `DG_RESET_INTERVAL * 3 * 10 + 50000;
      #(limit);
      $display("watchdog expired after %0t ns", limit);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : run
      entry_t e;
      hps_fpga_reset_n = 1'b0;
      bus_write = 1'b0;
      bus_read = 1'b0;
      bus_addr = '0;
      bus_wdata = '0;
      chk_en = 1'b0;
      exp_interval = `DG_RESET_INTERVAL;
      exp_polarity = '0;
      rd_kind = 2'd0;
      rd_exp = '0;
      rd_mask = '0;
      foreach (exp_pairs[c]) exp_pairs[c] = '0;
      build_table();
      built = 1'b1;
      repeat (2) @(negedge clk100);
      hps_fpga_reset_n = 1'b1;
      foreach (steps[i]) begin
         e = steps[i];
         case (e.op)
            OP_WR: begin
               bus_addr  = e.addr;
               bus_wdata = e.data;
               bus_write = 1'b1;
               @(negedge clk100);
               bus_write = 1'b0;
            end
            OP_RD: begin
               rd_kind  = e.data[1:0];
               rd_exp   = e.exp;
               rd_mask  = e.mask;
               bus_addr = e.addr;
               bus_read = 1'b1;
               @(negedge clk100);
               bus_read = 1'b0;
               wait_rvalid();
            end
            OP_SYNC: repeat (int'(e.data)) wait_t0();
            OP_EXP: begin
               exp_interval = e.exp[31:0];
               exp_polarity = e.data[12:8];
               foreach (exp_pairs[c])
                  exp_pairs[c] = (e.data[2:0] < 3'd4) ? page_vals[e.data[1:0]][c] : '0;
               chk_en = 1'b1;
            end
            default: chk_en = 1'b0;
         endcase
      end
      @(negedge clk100);
      $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== tb_dg_checker.sv ====
// delay generator checker
// watches dg_t0, the pins and the read port and compares them with the
// expected interval, pairs, polarity and read values from the testbench
`timescale 1ns/1ns
`include "dg_defs.svh"

module tb_dg_checker (
   input  logic             clk100,
   input  logic             hps_fpga_reset_n,
   input  logic             dg_t0,
   input  dg_pkg::dg_pins_t dg_pins,
   input  logic             bus_read,
   input  logic             bus_rvalid,
   input  dg_pkg::dg_word_t bus_rdata,
   input  logic             chk_en,        // pin and spacing checks
   input  dg_pkg::dg_time_t exp_interval,
   input  dg_pkg::dg_word_t exp_pairs [`DG_NCHANNELS],
   input  dg_pkg::dg_pins_t exp_polarity,
   input  logic [1:0]       rd_kind,       // 0 value, 1 timestamp, 2 status
   input  dg_pkg::dg_word_t rd_exp,
   input  dg_pkg::dg_word_t rd_mask,
   output int               errors
);
   import dg_pkg::*;

   logic     live;
   dg_time_t cnt;        // cycles since dg_t0
   dg_time_t t0_seen;
   dg_time_t prev_t0_ts;
   dg_time_t prev_t0_st;
   dg_word_t prev_ts;
   dg_time_t prev_st;
   logic     have_ts;
   logic     have_st;
   logic     read_q;     // read one cycle back

   initial errors = 0;

   // ====================
   // period and pins
   // ====================
   always @(posedge clk100) begin : watch_pins
      dg_time_t pos;
      dg_time_t d;
      dg_time_t w;
      logic [`DG_NCHANNELS-1:0] ch;
      dg_pins_t want;
      if (!hps_fpga_reset_n) begin
         live    <= 1'b0;
         cnt     <= '0;
         t0_seen <= '0;
      end else begin
         pos = dg_t0 ? '0 : cnt + 1;
         if (dg_t0 && live && (cnt + 1 != exp_interval)) begin
            errors++;
            $display("CHECK FAILED dg_t0 spacing: expected %h, got %h", exp_interval, cnt + 1);
         end
         if (live || (dg_t0 && chk_en)) begin
            for (int c = 0; c < `DG_NCHANNELS; c++) begin
               d     = exp_pairs[c][63:32];
               w     = exp_pairs[c][31:0];
               ch[c] = (pos >= d) && (pos < d + w);
            end
            want = {ch[6], ch[4] | ch[5], ch[2] | ch[3], ch[1], ch[0]};
            want = ~(want ^ exp_polarity);   // active low unless mask set
            if (dg_pins !== want) begin
               errors++;
               $display("CHECK FAILED dg_pins at %0d: expected %h, got %h", pos, want, dg_pins);
            end
         end
         if (!chk_en) live <= 1'b0;
         else if (dg_t0) live <= 1'b1;
         if (dg_t0) t0_seen <= t0_seen + 1;
         cnt <= pos;
      end
   end

   // ====================
   // readback
   // ====================
   always @(posedge clk100) begin : watch_reads
      dg_word_t want;
      if (!hps_fpga_reset_n) begin
         have_ts <= 1'b0;
         have_st <= 1'b0;
         read_q  <= 1'b0;
      end else begin
         if (bus_rvalid !== read_q) begin
            errors++;
            $display("CHECK FAILED bus_rvalid: expected %h, got %h", read_q, bus_rvalid);
         end
         read_q <= bus_read;
         if (bus_rvalid) begin
            case (rd_kind)
               2'd1: begin
                  want = dg_word_t'(exp_interval) * dg_word_t'(t0_seen - prev_t0_ts);
                  if (have_ts && (bus_rdata - prev_ts != want)) begin
                     errors++;
                     $display("CHECK FAILED bus_rdata timestamp delta: expected %h, got %h",
                              want, bus_rdata - prev_ts);
                  end
                  prev_ts    <= bus_rdata;
                  prev_t0_ts <= t0_seen;
                  have_ts    <= 1'b1;
               end
               2'd2: begin
                  if (have_st && (bus_rdata[63:32] - prev_st != t0_seen - prev_t0_st)) begin
                     errors++;
                     $display("CHECK FAILED bus_rdata t0 count delta: expected %h, got %h",
                              t0_seen - prev_t0_st, bus_rdata[63:32] - prev_st);
                  end
                  prev_st    <= bus_rdata[63:32];
                  prev_t0_st <= t0_seen;
                  have_st    <= 1'b1;
               end
               default: begin
                  if ((bus_rdata & rd_mask) !== (rd_exp & rd_mask)) begin
                     errors++;
                     $display("CHECK FAILED bus_rdata: expected %h, got %h",
                              rd_exp & rd_mask, bus_rdata & rd_mask);
                  end
               end
            endcase
         end
      end
   end

endmodule

// ==== dg_top.sv ====
// delay generator top
// plain bus and pin ports, binds the bus and timing interfaces
// and connects sequencer, the delay channels and the output stage
`timescale 1ns/1ns
`include "dg_defs.svh"

module dg_top (
   input  logic             clk100,
   input  logic             hps_fpga_reset_n,
   input  logic             bus_write,
   input  logic             bus_read,
   input  dg_pkg::dg_addr_t bus_addr,
   input  dg_pkg::dg_word_t bus_wdata,
   output dg_pkg::dg_word_t bus_rdata,
   output logic             bus_rvalid,
   output dg_pkg::dg_pins_t dg_pins,
   output logic             dg_t0
);

   host_bus_if     bus ();
   pulse_timing_if timing ();

   // host side of the register bus
   assign bus.write  = bus_write;
   assign bus.read   = bus_read;
   assign bus.addr   = bus_addr;
   assign bus.wdata  = bus_wdata;
   assign bus_rdata  = bus.rdata;
   assign bus_rvalid = bus.rvalid;

   protocol_sequencer u_sequencer (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .bus              (bus.sequencer),
      .timing           (timing.source)
   );

   // ====================
   // delay channels
   // ====================
   for (genvar i = 0; i < `DG_NCHANNELS; i++) begin : g_channel
      delay_channel u_channel (
         .clk100           (clk100),
         .hps_fpga_reset_n (hps_fpga_reset_n),
         .timing           (timing.channel),
         .index            (i)
      );
   end

   output_stage u_output (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .bus              (bus.out_stage),
      .timing           (timing.sink),
      .dg_pins          (dg_pins),
      .dg_t0            (dg_t0)
   );

endmodule

// ==== output_stage.sv ====
// output stage
// groups the channel pulses onto the five pins, applies the polarity mask
// and registers pins and t0 with matching latency
`timescale 1ns/1ns
`include "dg_defs.svh"

module output_stage (
   input  logic             clk100,
   input  logic             hps_fpga_reset_n,
   host_bus_if.out_stage    bus,
   pulse_timing_if.sink     timing,
   output dg_pkg::dg_pins_t dg_pins,
   output logic             dg_t0
);
   import dg_pkg::*;

   dg_pins_t polarity;   // 1 = active high
   dg_pins_t active;
   dg_pins_t level;
   logic     t0_d;       // matches the channel register

   // ====================
   // pin grouping
   // ====================
   assign active[0] = timing.pulses[0];                      // push
   assign active[1] = timing.pulses[1];                      // inject
   assign active[2] = timing.pulses[2] | timing.pulses[3];   // eject 0,1
   assign active[3] = timing.pulses[4] | timing.pulses[5];   // gate 0,1
   assign active[4] = timing.pulses[6];                      // adc

   // active low unless the mask bit is set
   assign level = ~(active ^ polarity);

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         polarity <= '0;
      end else if (bus.write && bus.addr == dg_addr_t'(`DG_REG_POLARITY)) begin
         polarity <= bus.wdata[`DG_NPINS-1:0];
      end
   end

   // ====================
   // output registers
   // ====================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         t0_d    <= 1'b0;
         dg_t0   <= 1'b0;
         dg_pins <= '1;       // inactive with mask cleared
      end else begin
         t0_d    <= timing.t0;
         dg_t0   <= t0_d;
         dg_pins <= level;
      end
   end

endmodule

// ==== delay_channel.sv ====
// delay channel
// picks its own delay/width pair and registers one pulse per period,
// high from delay to delay + width - 1 counted from t0
`timescale 1ns/1ns
`include "dg_defs.svh"

module delay_channel (
   input  logic            clk100,
   input  logic            hps_fpga_reset_n,
   pulse_timing_if.channel timing,
   input  int              index
);
   import dg_pkg::*;

   dg_time_t             delay;
   dg_time_t             width;
   logic [`DG_TIME_W:0]  pulse_end;   // one extra bit, no wrap
   logic [`DG_TIME_W:0]  count_ext;
   logic                 in_window;
   logic                 pulse_q;

   // pair layout is {delay, width}
   assign delay = timing.active_pairs[index][`DG_DATA_W-1 -: `DG_TIME_W];
   assign width = timing.active_pairs[index][`DG_TIME_W-1:0];

   assign pulse_end = {1'b0, delay} + {1'b0, width};
   assign count_ext = {1'b0, timing.period_count};

   // empty window when width is zero
   assign in_window = (count_ext >= {1'b0, delay}) && (count_ext < pulse_end);

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pulse_q <= 1'b0;
      end else begin
         pulse_q <= in_window;   // same latency as t0 in output stage
      end
   end

   assign timing.pulses[index] = pulse_q;

   // pairs only change at the wrap, so a zero width holds a whole period
   a_no_pulse_zero_width: assert property (@(posedge clk100)
      disable iff (!hps_fpga_reset_n)
      (width == '0) |=> !pulse_q);

endmodule

// ==== protocol_sequencer.sv ====
// protocol sequencer
// holds the protocol pages and register map, runs the period counter,
// applies committed pages at the period wrap and answers bus reads
`timescale 1ns/1ns
`include "dg_defs.svh"

module protocol_sequencer (
   input  logic            clk100,
   input  logic            hps_fpga_reset_n,
   host_bus_if.sequencer   bus,
   pulse_timing_if.source  timing
);
   import dg_pkg::*;

   localparam int PAIR_W = $clog2(`DG_NCHANNELS);

   // ====================
   // storage
   // ====================
   dg_word_t    page_mem [`DG_NPAGES][`DG_NCHANNELS];  // user pages
   dg_word_t    pending_pairs [`DG_NCHANNELS];
   dg_word_t    active_pairs [`DG_NCHANNELS];
   dg_time_t    user_interval;
   dg_time_t    pending_interval;
   dg_time_t    active_interval;
   dg_page_t    pending_page;
   dg_page_t    active_page;
   logic [2:0]  flags;              // view, page
   dg_word_t    cycle_count;        // free running
   dg_word_t    timestamp;
   dg_time_t    t0_count;
   seq_state_t  state;
   logic        t0_q;
   dg_time_t    period_q;

   dg_page_t    user_page;
   logic        view;
   dg_addr_t    pair_off;
   logic [PAIR_W-1:0] pair_sel;
   logic        is_pair;
   logic        commit_valid;
   dg_page_t    commit_page;
   logic        wrap;
   dg_word_t    rd_mux;

   assign user_page    = flags[1:0];
   assign view         = flags[2];
   assign pair_off     = bus.addr - dg_addr_t'(`DG_REG_PAIR0);
   assign pair_sel     = pair_off[PAIR_W-1:0];
   assign is_pair      = (bus.addr >= dg_addr_t'(`DG_REG_PAIR0)) &&
                         (bus.addr < dg_addr_t'(`DG_REG_PAIR0 + `DG_NCHANNELS));
   assign commit_valid = bus.write && (bus.addr == dg_addr_t'(`DG_REG_COMMIT)) &&
                         bus.wdata[0];
   assign commit_page  = bus.wdata[2:1];
   assign wrap         = (period_q >= active_interval - 1'b1);  // last cycle of period

   // ====================
   // register writes
   // ====================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int p = 0; p < `DG_NPAGES; p++) begin
            for (int c = 0; c < `DG_NCHANNELS; c++) begin
               page_mem[p][c] <= '0;
            end
         end
         user_interval <= dg_time_t'(`DG_RESET_INTERVAL);
         flags         <= '0;
      end else if (bus.write) begin
         if (bus.addr == dg_addr_t'(`DG_REG_INTERVAL)) begin
            user_interval <= bus.wdata[`DG_TIME_W-1:0];   // clamped only at commit
         end
         if (is_pair && !view) begin
            page_mem[user_page][pair_sel] <= bus.wdata;
         end
         if (bus.addr == dg_addr_t'(`DG_REG_FLAGS)) begin
            flags <= bus.wdata[2:0];
         end
      end
   end

   // commit snapshot, waits here until the wrap
   always_ff @(posedge clk100) begin
      if (commit_valid) begin
         pending_interval <= (user_interval < dg_time_t'(`DG_MIN_INTERVAL)) ?
                             dg_time_t'(`DG_MIN_INTERVAL) : user_interval;
         pending_pairs    <= page_mem[commit_page];
         pending_page     <= commit_page;
      end
   end

   // ====================
   // period counter
   // ====================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         state           <= seq_idle;
         t0_q            <= 1'b0;
         period_q        <= '0;
         active_interval <= dg_time_t'(`DG_RESET_INTERVAL);
         active_page     <= '0;
         for (int c = 0; c < `DG_NCHANNELS; c++) begin
            active_pairs[c] <= '0;   // no pulses until a commit
         end
      end else begin
         t0_q <= 1'b0;
         case (state)
            seq_idle: begin
               t0_q     <= 1'b1;     // first period starts right away
               period_q <= '0;
            end
            default: begin
               if (wrap) begin
                  t0_q     <= 1'b1;
                  period_q <= '0;
                  if (state == seq_reload) begin
                     active_interval <= pending_interval;
                     active_pairs    <= pending_pairs;
                     active_page     <= pending_page;
                  end
               end else begin
                  period_q <= period_q + 1'b1;
               end
            end
         endcase

         if (commit_valid) begin
            state <= seq_reload;      // a commit in the wrap cycle waits a period
         end else if (state == seq_idle || wrap) begin
            state <= seq_run;
         end
      end
   end

   assign timing.t0           = t0_q;
   assign timing.period_count = period_q;
   assign timing.active_pairs = active_pairs;

   // timestamp and t0 count
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         cycle_count <= '0;
         timestamp   <= '0;
         t0_count    <= '0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
         if (t0_q) begin
            timestamp <= cycle_count;
            t0_count  <= t0_count + 1'b1;
         end
      end
   end

   // ====================
   // readback
   // ====================
   always_comb begin
      rd_mux = '0;
      if (is_pair) begin
         rd_mux = view ? active_pairs[pair_sel] : page_mem[user_page][pair_sel];
      end else begin
         case (bus.addr)
            dg_addr_t'(`DG_REG_INTERVAL):
               rd_mux = dg_word_t'(view ? active_interval : user_interval);
            dg_addr_t'(`DG_REG_FLAGS):     rd_mux = dg_word_t'(flags);
            dg_addr_t'(`DG_REG_TIMESTAMP): rd_mux = timestamp;
            dg_addr_t'(`DG_REG_STATUS):    rd_mux = {t0_count, dg_time_t'(active_page)};
            dg_addr_t'(`DG_REG_COMMIT):
               rd_mux = {dg_time_t'(`DG_MODEL_NUMBER), dg_time_t'(0)};
            default:                       rd_mux = '0;  // polarity is write only
         endcase
      end
   end

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         bus.rvalid <= 1'b0;
      end else begin
         bus.rvalid <= bus.read;
      end
   end

   always_ff @(posedge clk100) begin
      if (bus.read) begin
         bus.rdata <= rd_mux;
      end
   end

   // commit clamp must carry through to the live period
   a_min_interval: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      active_interval >= dg_time_t'(`DG_MIN_INTERVAL));

   a_rvalid_follows_read: assert property (@(posedge clk100)
      disable iff (!hps_fpga_reset_n)
      bus.read |=> bus.rvalid);

endmodule

// ==== pulse_timing_if.sv ====
// period timing and channel pulses
// sequencer drives t0, period count and active pairs, channels return pulses
`timescale 1ns/1ns
`include "dg_defs.svh"

interface pulse_timing_if;
   import dg_pkg::*;

   logic                     t0;            // one cycle per period
   dg_time_t                 period_count;  // zero in the t0 cycle
   dg_word_t                 active_pairs [`DG_NCHANNELS];  // {delay, width}
   logic [`DG_NCHANNELS-1:0] pulses;        // one bit per channel

   modport source (
      output t0, period_count, active_pairs
   );

   modport channel (
      input  period_count, active_pairs,
      output pulses
   );

   modport sink (
      input  t0, pulses
   );

endinterface

// ==== host_bus_if.sv ====
// host register bus
// single-cycle writes, reads answered with rvalid one cycle later
`timescale 1ns/1ns

interface host_bus_if;
   import dg_pkg::*;

   logic     write;    // accepted in its own cycle
   logic     read;
   dg_addr_t addr;
   dg_word_t wdata;
   dg_word_t rdata;    // valid with rvalid
   logic     rvalid;

   modport owner (
      output write, read, addr, wdata,
      input  rdata, rvalid
   );

   modport sequencer (
      input  write, read, addr, wdata,
      output rdata, rvalid
   );

   // output stage only snoops polarity writes
   modport out_stage (
      input  write, addr, wdata
   );

endinterface

// ==== dg_pkg.sv ====
// delay generator types
// vector typedefs for bus, timing and pins, plus the period state enum
`include "dg_defs.svh"

package dg_pkg;

   // ====================
   // vectors
   // ====================
   typedef logic [`DG_TIME_W-1:0] dg_time_t;     // clk100 cycle count
   typedef logic [`DG_DATA_W-1:0] dg_word_t;     // bus word, delay in upper half
   typedef logic [`DG_ADDR_W-1:0] dg_addr_t;     // register address

   typedef logic [$clog2(`DG_NPAGES)-1:0] dg_page_t;  // protocol page number

   // pin order: push, inject, eject, gate, adc from bit 0 up
   typedef logic [`DG_NPINS-1:0] dg_pins_t;

   // ====================
   // sequencer state
   // ====================
   // idle only lasts until the first t0 after reset
   // reload means a committed page waits for the next wrap
   typedef enum logic [1:0] {
      seq_idle,
      seq_run,
      seq_reload
   } seq_state_t;

endpackage

// ==== dg_defs.svh ====
// delay generator definitions
// channel and page counts, widths, interval limits and the register map
`ifndef DG_DEFS_SVH
`define DG_DEFS_SVH

// ====================
// sizes
// ====================
`define DG_NCHANNELS      7     // delay channels
`define DG_NPAGES         4     // protocol pages
`define DG_NPINS          5     // combined output pins
`define DG_TIME_W         32    // delays, widths, intervals, counts
`define DG_DATA_W         64    // bus word
`define DG_ADDR_W         4     // bus address

// ====================
// timing limits
// ====================
`define DG_MIN_INTERVAL   1000  // 10 us at clk100
`define DG_RESET_INTERVAL 2000  // short default period
`define DG_MODEL_NUMBER   32'h20210801

// ====================
// register map
// ====================
`define DG_REG_INTERVAL   0
`define DG_REG_PAIR0      1     // pairs at 1 through 7
`define DG_REG_POLARITY   11    // write only
`define DG_REG_FLAGS      12
`define DG_REG_TIMESTAMP  13
`define DG_REG_STATUS     14
`define DG_REG_COMMIT     15

`endif
